/* include/riscv_sys_cfg.svh */
`ifndef RISCV_SYS_CFG_SVH
`define RISCV_SYS_CFG_SVH

////////////////////
// Bus widths
////////////////////

// Physical address width
`define PLEN 32
// Data word width
`define XLEN 32
// Word index bits into one RAM
`define WORD_IDX_W 10

////////////////////
// Memory map
////////////////////

// Code RAM region, 4 KB of words
`define CODE_BASE 32'h8000_0000
`define CODE_WORDS 1024

// Host interface words
`define TOHOST_ADDR 32'h8000_1000
`define UART_TX_ADDR 32'h8000_1080

// Data RAM region, 4 KB of words
`define DATA_BASE 32'h8000_2000
`define DATA_WORDS 1024

`endif

/* project.f */
+incdir+include
src/riscv_sys_pkg.sv
src/pma_checker.sv
src/dbg_access_ctrl.sv
src/wb_spram.sv
src/host_io_regs.sv
src/pu_riscv_synthesis.sv
verification/tb_checker.sv
verification/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_top \
  -Mdir build \
  -f project.f

./build/Vtb_top | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* src/dbg_access_ctrl.sv */
module dbg_access_ctrl
  import riscv_sys_pkg::*;
(
  input  logic      HCLK,
  input  logic      reset_i,
  // Debug strobe interface
  input  logic      dbg_strb_i,
  input  logic      dbg_we_i,
  input  paddr_t    dbg_addr_i,
  input  xdata_t    dbg_dati_i,
  output xdata_t    dbg_dato_o,
  output logic      dbg_ack_o,
  output logic      dbg_err_o,
  // PMA checker
  output paddr_t    req_addr_o,
  output logic      req_we_o,
  input  target_e   acc_target_i,
  input  logic      acc_fault_i,
  // Shared slave bus
  output word_idx_t bus_idx_o,
  output xdata_t    bus_wdat_o,
  output logic      bus_we_o,
  output logic      is_uart_o,
  output logic      code_stb_o,
  output logic      data_stb_o,
  output logic      host_stb_o,
  input  xdata_t    code_rdat_i,
  input  xdata_t    data_rdat_i,
  input  xdata_t    host_rdat_i,
  input  logic      code_ack_i,
  input  logic      data_ack_i,
  input  logic      host_ack_i
);

  localparam int IDX_W = $bits(word_idx_t);

  acc_state_e state_q;
  acc_state_e state_d;
  paddr_t     addr_q;
  logic       we_q;
  xdata_t     dati_q;
  target_e    tgt_q;
  logic       ack_q;
  logic       err_q;
  xdata_t     sel_rdat;
  logic       sel_ack;

  ////////////////////
  // FSM
  ////////////////////

  // Strobes outside IDLE are dropped
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (dbg_strb_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        // Faults skip the bus cycle
        state_d = acc_fault_i ? DONE : BUS;
      end
      BUS: begin
        state_d = DONE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      state_q <= IDLE;
      tgt_q   <= TGT_NONE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Ack for the single DONE cycle
      ack_q   <= (state_d == DONE);
      // Verdict of the checker
      if (state_q == CHECK) begin
        tgt_q <= acc_target_i;
        err_q <= acc_fault_i;
      end
    end
  end

  // Request capture
  always_ff @(posedge HCLK) begin
    if (state_q == IDLE && dbg_strb_i) begin
      addr_q <= dbg_addr_i;
      we_q   <= dbg_we_i;
      dati_q <= dbg_dati_i;
    end
  end

  ////////////////////
  // Slave side
  ////////////////////

  assign req_addr_o = addr_q;
  assign req_we_o   = we_q;

  // Both RAM bases sit on 4 KB boundaries
  assign bus_idx_o  = addr_q[IDX_W+1:2];
  assign bus_wdat_o = dati_q;
  assign bus_we_o   = we_q;
  assign is_uart_o  = (tgt_q == TGT_UART);

  // One cycle strobe in BUS
  assign code_stb_o = (state_q == BUS) && (tgt_q == TGT_CODE);
  assign data_stb_o = (state_q == BUS) && (tgt_q == TGT_DATA);
  assign host_stb_o = (state_q == BUS) && (tgt_q == TGT_TOHOST || tgt_q == TGT_UART);

  // Read data and ack of the addressed slave
  always_comb begin
    sel_rdat = '0;
    sel_ack  = 1'b0;
    case (tgt_q)
      TGT_CODE: begin
        sel_rdat = code_rdat_i;
        sel_ack  = code_ack_i;
      end
      TGT_DATA: begin
        sel_rdat = data_rdat_i;
        sel_ack  = data_ack_i;
      end
      TGT_TOHOST, TGT_UART: begin
        sel_rdat = host_rdat_i;
        sel_ack  = host_ack_i;
      end
      default: begin
        sel_rdat = '0;
        sel_ack  = 1'b0;
      end
    endcase
  end

  ////////////////////
  // Debug response
  ////////////////////

  assign dbg_ack_o  = ack_q;
  assign dbg_err_o  = ack_q & err_q;
  // Zero for writes and faults
  assign dbg_dato_o = (ack_q && !err_q && !we_q && sel_ack) ? sel_rdat : '0;

  // Never two slaves in one cycle
  a_one_stb: assert property (@(posedge HCLK) disable iff (reset_i)
    $onehot0({code_stb_o, data_stb_o, host_stb_o}));

  // Slave acks only in DONE
  a_ack_done: assert property (@(posedge HCLK) disable iff (reset_i)
    (code_ack_i || data_ack_i || host_ack_i) |-> state_q == DONE);

  // Slave answers the cycle after its strobe
  a_slave_ack: assert property (@(posedge HCLK) disable iff (reset_i)
    state_q == BUS |=> sel_ack);

endmodule

/* src/host_io_regs.sv */
module host_io_regs
  import riscv_sys_pkg::*;
(
  input  logic       HCLK,
  input  logic       reset_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic       is_uart_i,
  input  xdata_t     wdat_i,
  output xdata_t     rdat_o,
  output logic       ack_o,
  // Host side
  output xdata_t     tohost_o,
  output logic       tohost_strb_o,
  output logic [7:0] uart_tx_o,
  output logic       uart_tx_strb_o
);

  xdata_t     tohost_q;
  logic       tohost_strb_q;
  logic [7:0] uart_q;
  logic       uart_strb_q;
  xdata_t     rdat_q;
  logic       ack_q;
  logic       tohost_wr;
  logic       uart_wr;

  // Register select from the controller's decode
  assign tohost_wr = stb_i & we_i & ~is_uart_i;
  assign uart_wr   = stb_i & we_i & is_uart_i;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      ack_q         <= 1'b0;
      tohost_q      <= '0;
      tohost_strb_q <= 1'b0;
      uart_strb_q   <= 1'b0;
    end else begin
      ack_q         <= stb_i;
      // Pulses line up with the ack
      tohost_strb_q <= tohost_wr;
      uart_strb_q   <= uart_wr;
      if (tohost_wr) begin
        tohost_q <= wdat_i;
      end
    end
  end

  // TX byte and read data
  always_ff @(posedge HCLK) begin
    if (uart_wr) begin
      uart_q <= wdat_i[7:0];
    end
    if (stb_i) begin
      rdat_q <= (!we_i && !is_uart_i) ? tohost_q : '0;
    end
  end

  assign rdat_o         = rdat_q;
  assign ack_o          = ack_q;
  assign tohost_o       = tohost_q;
  assign tohost_strb_o  = tohost_strb_q;
  assign uart_tx_o      = uart_q;
  assign uart_tx_strb_o = uart_strb_q;

  // PMA keeps reads away from the TX register
  a_uart_wo: assert property (@(posedge HCLK) disable iff (reset_i)
    stb_i && is_uart_i |-> we_i);

endmodule

/* src/pma_checker.sv */
`include "riscv_sys_cfg.svh"

module pma_checker
  import riscv_sys_pkg::*;
(
  input  paddr_t  req_addr_i,
  input  logic    req_we_i,
  output target_e acc_target_o,
  output logic    acc_fault_o
);

  // Region sizes in bytes
  localparam paddr_t CODE_BYTES = paddr_t'(`CODE_WORDS * 4);
  localparam paddr_t DATA_BYTES = paddr_t'(`DATA_WORDS * 4);

  // Single word IO addresses
  localparam paddr_t TOHOST_W = `TOHOST_ADDR;
  localparam paddr_t UART_W   = `UART_TX_ADDR;

  paddr_t code_off;
  paddr_t data_off;
  logic   hit_code;
  logic   hit_tohost;
  logic   hit_uart;
  logic   hit_data;
  logic   misaligned;
  logic   rd_ok;
  logic   wr_ok;

  ////////////////////
  // Region match
  ////////////////////

  // Offsets wrap below the base so one compare covers both bounds
  assign code_off = req_addr_i - paddr_t'(`CODE_BASE);
  assign data_off = req_addr_i - paddr_t'(`DATA_BASE);

  assign hit_code   = code_off < CODE_BYTES;
  assign hit_data   = data_off < DATA_BYTES;
  // IO words compare above the byte offset
  assign hit_tohost = req_addr_i[`PLEN-1:2] == TOHOST_W[`PLEN-1:2];
  assign hit_uart   = req_addr_i[`PLEN-1:2] == UART_W[`PLEN-1:2];

  // Word accesses only
  assign misaligned = |req_addr_i[1:0];

  ////////////////////
  // Permissions
  ////////////////////

  // First hit wins, same order as the region table
  always_comb begin
    acc_target_o = TGT_NONE;
    rd_ok        = 1'b0;
    wr_ok        = 1'b0;
    if (hit_code) begin
      acc_target_o = TGT_CODE;
      rd_ok        = 1'b1;
      wr_ok        = 1'b1;
    end else if (hit_tohost) begin
      acc_target_o = TGT_TOHOST;
      rd_ok        = 1'b1;
      wr_ok        = 1'b1;
    end else if (hit_uart) begin
      // TX register is write only
      acc_target_o = TGT_UART;
      wr_ok        = 1'b1;
    end else if (hit_data) begin
      acc_target_o = TGT_DATA;
      rd_ok        = 1'b1;
      wr_ok        = 1'b1;
    end
  end

  // Unmapped regions have neither permission
  assign acc_fault_o = misaligned | (req_we_i ? ~wr_ok : ~rd_ok);

endmodule

/* src/pu_riscv_synthesis.sv */
`include "riscv_sys_cfg.svh"

module pu_riscv_synthesis
  import riscv_sys_pkg::*;
(
  input  logic       HCLK,
  input  logic       reset_i,
  // Debug access port
  input  logic       dbg_strb_i,
  input  logic       dbg_we_i,
  input  paddr_t     dbg_addr_i,
  input  xdata_t     dbg_dati_i,
  output xdata_t     dbg_dato_o,
  output logic       dbg_ack_o,
  output logic       dbg_err_o,
  // Host interface
  output xdata_t     tohost_o,
  output logic       tohost_strb_o,
  output logic [7:0] uart_tx_o,
  output logic       uart_tx_strb_o
);

  // PMA check
  paddr_t    req_addr;
  logic      req_we;
  target_e   acc_target;
  logic      acc_fault;

  // Shared slave bus
  word_idx_t bus_idx;
  xdata_t    bus_wdat;
  logic      bus_we;
  logic      is_uart;

  // Per slave strobe, data and ack
  logic      code_stb;
  logic      data_stb;
  logic      host_stb;
  xdata_t    code_rdat;
  xdata_t    data_rdat;
  xdata_t    host_rdat;
  logic      code_ack;
  logic      data_ack;
  logic      host_ack;

  ////////////////////
  // Bus master
  ////////////////////

  dbg_access_ctrl dbg_ctrl (
    .HCLK         (HCLK),
    .reset_i      (reset_i),
    .dbg_strb_i   (dbg_strb_i),
    .dbg_we_i     (dbg_we_i),
    .dbg_addr_i   (dbg_addr_i),
    .dbg_dati_i   (dbg_dati_i),
    .dbg_dato_o   (dbg_dato_o),
    .dbg_ack_o    (dbg_ack_o),
    .dbg_err_o    (dbg_err_o),
    .req_addr_o   (req_addr),
    .req_we_o     (req_we),
    .acc_target_i (acc_target),
    .acc_fault_i  (acc_fault),
    .bus_idx_o    (bus_idx),
    .bus_wdat_o   (bus_wdat),
    .bus_we_o     (bus_we),
    .is_uart_o    (is_uart),
    .code_stb_o   (code_stb),
    .data_stb_o   (data_stb),
    .host_stb_o   (host_stb),
    .code_rdat_i  (code_rdat),
    .data_rdat_i  (data_rdat),
    .host_rdat_i  (host_rdat),
    .code_ack_i   (code_ack),
    .data_ack_i   (data_ack),
    .host_ack_i   (host_ack)
  );

  // Fixed region table
  pma_checker pma (
    .req_addr_i   (req_addr),
    .req_we_i     (req_we),
    .acc_target_o (acc_target),
    .acc_fault_o  (acc_fault)
  );

  ////////////////////
  // Slaves
  ////////////////////

  // Code RAM
  wb_spram #(
    .DEPTH (`CODE_WORDS)
  ) instruction_ram (
    .HCLK    (HCLK),
    .reset_i (reset_i),
    .stb_i   (code_stb),
    .we_i    (bus_we),
    .idx_i   (bus_idx),
    .wdat_i  (bus_wdat),
    .rdat_o  (code_rdat),
    .ack_o   (code_ack)
  );

  // Data RAM
  wb_spram #(
    .DEPTH (`DATA_WORDS)
  ) data_ram (
    .HCLK    (HCLK),
    .reset_i (reset_i),
    .stb_i   (data_stb),
    .we_i    (bus_we),
    .idx_i   (bus_idx),
    .wdat_i  (bus_wdat),
    .rdat_o  (data_rdat),
    .ack_o   (data_ack)
  );

  // TOHOST and UART TX words
  host_io_regs host_io (
    .HCLK           (HCLK),
    .reset_i        (reset_i),
    .stb_i          (host_stb),
    .we_i           (bus_we),
    .is_uart_i      (is_uart),
    .wdat_i         (bus_wdat),
    .rdat_o         (host_rdat),
    .ack_o          (host_ack),
    .tohost_o       (tohost_o),
    .tohost_strb_o  (tohost_strb_o),
    .uart_tx_o      (uart_tx_o),
    .uart_tx_strb_o (uart_tx_strb_o)
  );

endmodule

/* src/riscv_sys_pkg.sv */
`include "riscv_sys_cfg.svh"

package riscv_sys_pkg;

  ////////////////////
  // Vector types
  ////////////////////

  // Physical address on the debug port
  typedef logic [`PLEN-1:0] paddr_t;

  // One bus data word
  typedef logic [`XLEN-1:0] xdata_t;

  // Word index into either RAM
  typedef logic [`WORD_IDX_W-1:0] word_idx_t;

  ////////////////////
  // Enumerations
  ////////////////////

  // Slave chosen by the PMA decode
  typedef enum logic [2:0] {
    TGT_CODE,
    TGT_DATA,
    TGT_TOHOST,
    TGT_UART,
    TGT_NONE
  } target_e;

  // Debug access controller states
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    BUS,
    DONE
  } acc_state_e;

endpackage

/* src/wb_spram.sv */
module wb_spram
  import riscv_sys_pkg::*;
#(
  parameter int DEPTH = 2 ** $bits(word_idx_t)
) (
  input  logic      HCLK,
  input  logic      reset_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  word_idx_t idx_i,
  input  xdata_t    wdat_i,
  output xdata_t    rdat_o,
  output logic      ack_o
);

  xdata_t mem [DEPTH];
  xdata_t rdat_q;
  logic   ack_q;

  ////////////////////
  // Array
  ////////////////////

  // Write port
  always_ff @(posedge HCLK) begin
    if (stb_i && we_i) begin
      mem[idx_i] <= wdat_i;
    end
  end

  // Read word registered on any strobe, old data on a write
  always_ff @(posedge HCLK) begin
    if (stb_i) begin
      rdat_q <= mem[idx_i];
    end
  end

  ////////////////////
  // Handshake
  ////////////////////

  // Fixed one cycle latency
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
    end
  end

  assign rdat_o = rdat_q;
  assign ack_o  = ack_q;

endmodule

/* verification/tb_checker.sv */
`include "riscv_sys_cfg.svh"

module tb_checker
  import riscv_sys_pkg::*;
(
  input  logic       HCLK,
  input  logic       reset_i,
  input  logic       dbg_strb_i,
  input  logic       dbg_we_i,
  input  paddr_t     dbg_addr_i,
  input  xdata_t     dbg_dati_i,
  input  xdata_t     dbg_dato_o,
  input  logic       dbg_ack_o,
  input  logic       dbg_err_o,
  input  xdata_t     tohost_o,
  input  logic       tohost_strb_o,
  input  logic [7:0] uart_tx_o,
  input  logic       uart_tx_strb_o,
  output int         err_count_o,
  output int         check_count_o
);

  // Region codes of the memory map
  localparam int R_CODE   = 0;
  localparam int R_DATA   = 1;
  localparam int R_TOHOST = 2;
  localparam int R_UART   = 3;
  localparam int R_NONE   = 4;

  localparam paddr_t CODE_END = `CODE_BASE + `CODE_WORDS * 4;
  localparam paddr_t DATA_END = `DATA_BASE + `DATA_WORDS * 4;
  // Cycles after the strobe edge before an ack counts as lost
  localparam int ACK_LIMIT = 6;

  xdata_t code_model [`CODE_WORDS];
  xdata_t data_model [`DATA_WORDS];
  xdata_t tohost_model;

  // Request in flight
  logic   busy;
  paddr_t req_addr;
  logic   req_we;
  xdata_t req_dat;
  logic   exp_err;
  xdata_t exp_dat;
  int     exp_lat;
  int     lat;
  logic   exp_tohost_strb;
  logic   exp_uart_strb;
  int     errors;
  int     checks;

  assign err_count_o   = errors;
  assign check_count_o = checks;

  initial begin
    errors = 0;
    checks = 0;
    busy   = 1'b0;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int region_of(input paddr_t addr);
    if (addr >= `CODE_BASE && addr < CODE_END) begin
      return R_CODE;
    end
    if (addr == `TOHOST_ADDR) begin
      return R_TOHOST;
    end
    if (addr == `UART_TX_ADDR) begin
      return R_UART;
    end
    if (addr >= `DATA_BASE && addr < DATA_END) begin
      return R_DATA;
    end
    return R_NONE;
  endfunction

  function automatic word_idx_t ram_word(input paddr_t addr, input paddr_t base);
    return word_idx_t'((addr - base) >> 2);
  endfunction

  // Expected {err, read data} of one access
  function automatic logic [32:0] ref_response(input paddr_t addr, input logic we);
    int     rgn;
    logic   fault;
    xdata_t rdat;
    rgn   = region_of(addr);
    fault = (addr[1:0] != 2'b00) || rgn == R_NONE || (rgn == R_UART && !we);
    rdat  = '0;
    if (!fault && !we) begin
      case (rgn)
        R_CODE:   rdat = code_model[ram_word(addr, `CODE_BASE)];
        R_DATA:   rdat = data_model[ram_word(addr, `DATA_BASE)];
        R_TOHOST: rdat = tohost_model;
        default:  rdat = '0;
      endcase
    end
    return {fault, rdat};
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("** Error %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic report_event(input string msg);
    $display("Error: %s at %0t", msg, $time);
    errors++;
  endtask

  ////////////////////
  // Compare
  ////////////////////

  always @(posedge HCLK) begin : monitor
    logic [32:0] resp;
    exp_tohost_strb = 1'b0;
    exp_uart_strb   = 1'b0;
    if (reset_i) begin
      busy         = 1'b0;
      tohost_model = '0;
    end else begin
      if (busy) begin
        lat++;
        if (dbg_ack_o) begin
          checks++;
          if (lat != exp_lat) begin
            report_value("dbg_ack_o latency", lat, exp_lat);
          end
          if (dbg_err_o !== exp_err) begin
            report_value("dbg_err_o", {31'b0, dbg_err_o}, {31'b0, exp_err});
          end
          if (dbg_dato_o !== exp_dat) begin
            report_value("dbg_dato_o", dbg_dato_o, exp_dat);
          end
          // Only allowed writes change state
          if (!exp_err && req_we) begin
            case (region_of(req_addr))
              R_CODE:   code_model[ram_word(req_addr, `CODE_BASE)] = req_dat;
              R_DATA:   data_model[ram_word(req_addr, `DATA_BASE)] = req_dat;
              R_TOHOST: begin
                tohost_model    = req_dat;
                exp_tohost_strb = 1'b1;
              end
              R_UART:   exp_uart_strb = 1'b1;
              default:  ;
            endcase
          end
          busy = 1'b0;
        end else if (lat >= ACK_LIMIT) begin
          report_event($sformatf("no dbg_ack_o for the access to 0x%08h", req_addr));
          busy = 1'b0;
        end
      end else begin
        if (dbg_ack_o) begin
          report_event("dbg_ack_o without a pending access");
        end
        // New request, strobes while busy are dropped by the DUT
        if (dbg_strb_i) begin
          req_addr = dbg_addr_i;
          req_we   = dbg_we_i;
          req_dat  = dbg_dati_i;
          resp     = ref_response(dbg_addr_i, dbg_we_i);
          exp_err  = resp[32];
          exp_dat  = resp[31:0];
          exp_lat  = exp_err ? 2 : 3;
          lat      = 0;
          busy     = 1'b1;
        end
      end

      if (dbg_err_o && !dbg_ack_o) begin
        report_event("dbg_err_o high without dbg_ack_o");
      end
      // IO pulses line up with the ack of their write
      if (tohost_strb_o !== exp_tohost_strb) begin
        if (exp_tohost_strb) begin
          report_event("missing tohost_strb_o pulse after a TOHOST write");
        end else begin
          report_event("tohost_strb_o pulsed without a TOHOST write");
        end
      end
      if (uart_tx_strb_o !== exp_uart_strb) begin
        if (exp_uart_strb) begin
          report_event("missing uart_tx_strb_o pulse after a UART write");
        end else begin
          report_event("uart_tx_strb_o pulsed without a UART write");
        end
      end
      if (exp_uart_strb && uart_tx_o !== req_dat[7:0]) begin
        report_value("uart_tx_o", {24'b0, uart_tx_o}, {24'b0, req_dat[7:0]});
      end
      if (tohost_o !== tohost_model) begin
        report_value("tohost_o", tohost_o, tohost_model);
      end
    end
  end

endmodule

/* verification/tb_top.sv */
`include "riscv_sys_cfg.svh"

module tb_top
  import riscv_sys_pkg::*;
();

  localparam int ACK_TIMEOUT = 16;
  localparam int N_PAIRS     = 12;

  logic       HCLK;
  logic       reset_i;
  logic       dbg_strb_i;
  logic       dbg_we_i;
  paddr_t     dbg_addr_i;
  xdata_t     dbg_dati_i;
  xdata_t     dbg_dato_o;
  logic       dbg_ack_o;
  logic       dbg_err_o;
  xdata_t     tohost_o;
  logic       tohost_strb_o;
  logic [7:0] uart_tx_o;
  logic       uart_tx_strb_o;

  logic [31:0] rng;
  int          timeouts;
  int          err_count;
  int          check_count;
  word_idx_t   offs [$];

  // Period 8
  always #4 HCLK = ~HCLK;

  pu_riscv_synthesis dut0 (.*);

  // Scoreboard on the same ports
  tb_checker chk0 (
    .err_count_o   (err_count),
    .check_count_o (check_count),
    .*
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Advances the shared generator
  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic paddr_t ram_addr(input paddr_t base, input word_idx_t off);
    return base + {20'b0, off, 2'b00};
  endfunction

  task automatic wait_ack(input paddr_t addr);
    int n;
    n = 0;
    while (!dbg_ack_o && n < ACK_TIMEOUT) begin
      @(negedge HCLK);
      n++;
    end
    if (!dbg_ack_o) begin
      $display("Timeout: no ack for the access to 0x%08h", addr);
      timeouts++;
    end
  endtask

  // One strobe cycle, then wait for the answer
  task automatic bus_access(input logic we, input paddr_t addr, input xdata_t wdat);
    @(negedge HCLK);
    dbg_strb_i = 1'b1;
    dbg_we_i   = we;
    dbg_addr_i = addr;
    dbg_dati_i = wdat;
    @(negedge HCLK);
    dbg_strb_i = 1'b0;
    wait_ack(addr);
  endtask

  // Write with a second write strobe held over while in CHECK
  task automatic overlap_access(input paddr_t addr, input xdata_t wdat,
                                input paddr_t addr2, input xdata_t wdat2);
    @(negedge HCLK);
    dbg_strb_i = 1'b1;
    dbg_we_i   = 1'b1;
    dbg_addr_i = addr;
    dbg_dati_i = wdat;
    @(negedge HCLK);
    dbg_addr_i = addr2;
    dbg_dati_i = wdat2;
    @(negedge HCLK);
    dbg_strb_i = 1'b0;
    wait_ack(addr);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    word_idx_t   off;
    paddr_t      addr;
    logic [31:0] rnd;
    HCLK       = 1'b0;
    reset_i    = 1'b1;
    dbg_strb_i = 1'b0;
    dbg_we_i   = 1'b0;
    dbg_addr_i = '0;
    dbg_dati_i = '0;
    rng        = 32'd58;
    timeouts   = 0;
    repeat (4) @(posedge HCLK);
    @(negedge HCLK);
    reset_i = 1'b0;
    // Quiet outputs checked while idle
    repeat (3) @(negedge HCLK);

    // Same offset in both RAMs, different words
    for (int i = 0; i < N_PAIRS; i++) begin
      off = word_idx_t'(rand_word());
      offs.push_back(off);
      bus_access(1'b1, ram_addr(`CODE_BASE, off), rand_word());
      bus_access(1'b1, ram_addr(`DATA_BASE, off), rand_word());
    end
    foreach (offs[i]) begin
      bus_access(1'b0, ram_addr(`CODE_BASE, offs[i]), '0);
      bus_access(1'b0, ram_addr(`DATA_BASE, offs[i]), '0);
    end

    // Misaligned, unmapped and UART read
    off = offs[0];
    bus_access(1'b1, ram_addr(`CODE_BASE, off) + 32'd1, rand_word());
    bus_access(1'b1, ram_addr(`DATA_BASE, off) + 32'd2, rand_word());
    bus_access(1'b0, ram_addr(`DATA_BASE, off) + 32'd3, '0);
    bus_access(1'b1, `TOHOST_ADDR + 32'd4, rand_word());
    bus_access(1'b0, `DATA_BASE + 32'h1000, '0);
    bus_access(1'b1, `CODE_BASE - 32'd4, rand_word());
    bus_access(1'b0, `UART_TX_ADDR, '0);
    // Random addresses below the code base
    repeat (4) begin
      rnd      = rand_word();
      addr     = rnd;
      addr[31] = 1'b0;
      bus_access(rnd[0], addr, rand_word());
    end
    // Faulted writes left the words alone
    bus_access(1'b0, ram_addr(`CODE_BASE, off), '0);
    bus_access(1'b0, ram_addr(`DATA_BASE, off), '0);

    // UART TX bytes
    repeat (3) bus_access(1'b1, `UART_TX_ADDR, rand_word());

    // TOHOST write then read back
    repeat (2) begin
      bus_access(1'b1, `TOHOST_ADDR, rand_word());
      bus_access(1'b0, `TOHOST_ADDR, '0);
    end

    // Busy strobes, valid and faulting first access
    overlap_access(ram_addr(`DATA_BASE, offs[1]), rand_word(),
                   ram_addr(`DATA_BASE, offs[2]), rand_word());
    overlap_access(ram_addr(`DATA_BASE, offs[3]) + 32'd2, rand_word(),
                   ram_addr(`CODE_BASE, offs[3]), rand_word());
    bus_access(1'b0, ram_addr(`DATA_BASE, offs[1]), '0);
    bus_access(1'b0, ram_addr(`DATA_BASE, offs[2]), '0);
    bus_access(1'b0, ram_addr(`DATA_BASE, offs[3]), '0);
    bus_access(1'b0, ram_addr(`CODE_BASE, offs[3]), '0);

    repeat (8) @(negedge HCLK);
    $display("Summary: %0d checks, %0d errors, %0d timeouts",
             check_count, err_count, timeouts);
    if (err_count == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
